/* hdl/vga_control.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_control #(
    parameter int CLK_DIV = 4                      // 100 MHz in, 25 MHz pixels
) (
    input  wire             clk,
    input  wire             reset,
    output vga_pkg::color_t r,
    output vga_pkg::color_t g,
    output vga_pkg::color_t b,
    output logic            horizontal_sync,
    output logic            vertical_sync
);

    logic                  pixel_tick;
    vga_pkg::pixel_coord_t h_count;
    vga_pkg::pixel_coord_t v_count;
    logic                  h_sync_raw;
    logic                  v_sync_raw;
    vga_pkg::color_t       red_p;
    vga_pkg::color_t       green_p;
    vga_pkg::color_t       blue_p;
    logic                  h_sync_p;
    logic                  v_sync_p;
    logic                  visible_p;

    // raster position and sync
    vga_timing #(.CLK_DIV(CLK_DIV)) vga_timing_i (
        .clk(clk), .reset(reset), .pixel_tick(pixel_tick),
        .h_count(h_count), .v_count(v_count),
        .h_sync_raw(h_sync_raw), .v_sync_raw(v_sync_raw)
    );

    // picture lookup, one pixel behind the counters
    vga_pattern vga_pattern_i (
        .clk(clk), .reset(reset), .pixel_tick(pixel_tick),
        .h_count(h_count), .v_count(v_count),
        .h_sync_raw(h_sync_raw), .v_sync_raw(v_sync_raw),
        .red_p(red_p), .green_p(green_p), .blue_p(blue_p),
        .h_sync_p(h_sync_p), .v_sync_p(v_sync_p), .visible_p(visible_p)
    );

    // blanking and pin registers, two pixels behind
    vga_output vga_output_i (
        .clk(clk), .reset(reset), .pixel_tick(pixel_tick),
        .red_p(red_p), .green_p(green_p), .blue_p(blue_p),
        .h_sync_p(h_sync_p), .v_sync_p(v_sync_p), .visible_p(visible_p),
        .r(r), .g(g), .b(b),
        .horizontal_sync(horizontal_sync), .vertical_sync(vertical_sync)
    );

endmodule

`default_nettype wire

/* hdl/vga_output.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_output (
    input  wire             clk,
    input  wire             reset,
    input  wire             pixel_tick,
    input  vga_pkg::color_t red_p,
    input  vga_pkg::color_t green_p,
    input  vga_pkg::color_t blue_p,
    input  wire             h_sync_p,
    input  wire             v_sync_p,
    input  wire             visible_p,
    output vga_pkg::color_t r,                     // pins, all straight from flops
    output vga_pkg::color_t g,
    output vga_pkg::color_t b,
    output logic            horizontal_sync,
    output logic            vertical_sync
);

    logic blank_q;                                 // pins forced dark this pixel

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            r               <= '0;
            g               <= '0;
            b               <= '0;
            horizontal_sync <= 1'b0;
            vertical_sync   <= 1'b0;
            blank_q         <= 1'b1;               // dark out of reset
        end
        else if (pixel_tick)
        begin
            r               <= visible_p ? red_p   : vga_pkg::COLOR_OFF;
            g               <= visible_p ? green_p : vga_pkg::COLOR_OFF;
            b               <= visible_p ? blue_p  : vga_pkg::COLOR_OFF;
            horizontal_sync <= h_sync_p;           // polarity unchanged
            vertical_sync   <= v_sync_p;
            blank_q         <= !visible_p;
        end
    end

    // porches and sync intervals must show black
    a_blank_dark: assert property (@(posedge clk) disable iff (reset)
        blank_q |-> (r == vga_pkg::COLOR_OFF) && (g == vga_pkg::COLOR_OFF)
                 && (b == vga_pkg::COLOR_OFF));

endmodule

`default_nettype wire

/* hdl/vga_pattern.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_pattern (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   pixel_tick,
    input  vga_pkg::pixel_coord_t h_count,
    input  vga_pkg::pixel_coord_t v_count,
    input  wire                   h_sync_raw,
    input  wire                   v_sync_raw,
    output vga_pkg::color_t       red_p,
    output vga_pkg::color_t       green_p,
    output vga_pkg::color_t       blue_p,
    output logic                  h_sync_p,        // aligned with color
    output logic                  v_sync_p,
    output logic                  visible_p        // pixel lies in 640x480 window
);

    logic            in_panel;                     // yellow region
    logic            in_band_a;                    // rows with two marks
    logic            in_band_b;                    // rows with the bar
    logic            on_mark_l;                    // left mark column
    logic            on_mark_r;                    // right mark column
    logic            on_bar;                       // bar columns, left to right mark
    logic            is_black;
    logic            in_window;
    vga_pkg::color_t red_n;
    vga_pkg::color_t green_n;
    vga_pkg::color_t blue_n;

    // region decode from the current position
    assign in_panel  = (h_count >= vga_pkg::PANEL_H_FIRST) && (h_count <= vga_pkg::PANEL_H_LAST)
                    && (v_count >= vga_pkg::PANEL_V_FIRST) && (v_count <= vga_pkg::PANEL_V_LAST);
    assign in_band_a = (v_count >= vga_pkg::BAND_A_V_FIRST) && (v_count <= vga_pkg::BAND_A_V_LAST);
    assign in_band_b = (v_count >= vga_pkg::BAND_B_V_FIRST) && (v_count <= vga_pkg::BAND_B_V_LAST);
    assign on_mark_l = (h_count >= vga_pkg::MARK_L_H_FIRST) && (h_count <= vga_pkg::MARK_L_H_LAST);
    assign on_mark_r = (h_count >= vga_pkg::MARK_R_H_FIRST) && (h_count <= vga_pkg::MARK_R_H_LAST);
    assign on_bar    = (h_count >= vga_pkg::MARK_L_H_FIRST) && (h_count <= vga_pkg::MARK_R_H_LAST);

    assign is_black  = (in_band_a && (on_mark_l || on_mark_r)) || (in_band_b && on_bar);

    assign in_window = (h_count >= vga_pkg::H_VIS_FIRST) && (h_count <= vga_pkg::H_VIS_LAST)
                    && (v_count >= vga_pkg::V_VIS_FIRST) && (v_count <= vga_pkg::V_VIS_LAST);

    // color rule, marks win over the panel
    always_comb
    begin
        red_n   = vga_pkg::COLOR_FULL;             // white by default
        green_n = vga_pkg::COLOR_FULL;
        blue_n  = vga_pkg::COLOR_FULL;
        if (in_panel && is_black)
        begin
            red_n   = vga_pkg::COLOR_OFF;
            green_n = vga_pkg::COLOR_OFF;
            blue_n  = vga_pkg::COLOR_OFF;
        end
        else if (in_panel)
        begin
            blue_n  = vga_pkg::COLOR_OFF;          // yellow, red plus green
        end
    end

    // stage register, loads once per pixel
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            red_p     <= '0;
            green_p   <= '0;
            blue_p    <= '0;
            h_sync_p  <= 1'b0;
            v_sync_p  <= 1'b0;
            visible_p <= 1'b0;
        end
        else if (pixel_tick)
        begin
            red_p     <= red_n;
            green_p   <= green_n;
            blue_p    <= blue_n;
            h_sync_p  <= h_sync_raw;               // sync follows the color by one stage
            v_sync_p  <= v_sync_raw;
            visible_p <= in_window;
        end
    end

    // the picture holds no pure blue or cyan
    a_no_blue_without_red: assert property (@(posedge clk) disable iff (reset)
        (blue_p != vga_pkg::COLOR_OFF) |-> (red_p != vga_pkg::COLOR_OFF));

endmodule

`default_nettype wire

/* hdl/vga_pkg.sv */
`default_nettype none

package vga_pkg;

    typedef logic [9:0] pixel_coord_t;             // raster counter value, h or v
    typedef logic [3:0] color_t;                   // one rgb channel

    // channel levels
    localparam color_t COLOR_FULL = 4'hf;
    localparam color_t COLOR_OFF  = 4'h0;

    // raster periods in pixel ticks and lines
    localparam pixel_coord_t H_TOTAL = 10'd800;
    localparam pixel_coord_t V_TOTAL = 10'd525;

    // sync high while count below these
    localparam pixel_coord_t H_SYNC_END = 10'd96;
    localparam pixel_coord_t V_SYNC_END = 10'd2;

    // visible window, inclusive bounds
    localparam pixel_coord_t H_VIS_FIRST = 10'd144;
    localparam pixel_coord_t H_VIS_LAST  = 10'd783;
    localparam pixel_coord_t V_VIS_FIRST = 10'd35;
    localparam pixel_coord_t V_VIS_LAST  = 10'd514;

    // yellow panel, everything else white
    localparam pixel_coord_t PANEL_H_FIRST = 10'd324;
    localparam pixel_coord_t PANEL_H_LAST  = 10'd603;
    localparam pixel_coord_t PANEL_V_FIRST = 10'd135;
    localparam pixel_coord_t PANEL_V_LAST  = 10'd413;

    // band a rows carry two short marks
    localparam pixel_coord_t BAND_A_V_FIRST = 10'd205;
    localparam pixel_coord_t BAND_A_V_LAST  = 10'd216;

    // band b rows carry one long bar
    localparam pixel_coord_t BAND_B_V_FIRST = 10'd305;
    localparam pixel_coord_t BAND_B_V_LAST  = 10'd309;

    // mark columns; band b spans left first to right last
    localparam pixel_coord_t MARK_L_H_FIRST = 10'd371;
    localparam pixel_coord_t MARK_L_H_LAST  = 10'd382;
    localparam pixel_coord_t MARK_R_H_FIRST = 10'd545;
    localparam pixel_coord_t MARK_R_H_LAST  = 10'd556;

endpackage

`default_nettype wire

/* hdl/vga_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_timing #(
    parameter int CLK_DIV = 4                      // clk cycles per pixel
) (
    input  wire                  clk,
    input  wire                  reset,
    output logic                 pixel_tick,       // one clk wide, once per pixel
    output vga_pkg::pixel_coord_t h_count,
    output vga_pkg::pixel_coord_t v_count,
    output logic                 h_sync_raw,       // positive sync, unregistered
    output logic                 v_sync_raw
);

    localparam int DIV_W = $clog2(CLK_DIV);        // divider width

    logic [DIV_W-1:0] div_count;                   // 0 .. CLK_DIV-1
    logic             h_wrap;                      // last pixel of a line

    // a divide by one would leave no gap between ticks
    if (CLK_DIV < 2) begin : g_div_check
        $error("vga_timing: CLK_DIV must be at least 2");
    end

    assign pixel_tick = (div_count == DIV_W'(CLK_DIV - 1));
    assign h_wrap     = (h_count == vga_pkg::H_TOTAL - 10'd1);

    // pixel strobe divider
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            div_count <= '0;
        end
        else if (pixel_tick)
        begin
            div_count <= '0;                       // restart period
        end
        else
        begin
            div_count <= div_count + 1'b1;
        end
    end

    // raster counters, both advance only on a tick
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            h_count <= '0;
            v_count <= '0;
        end
        else if (pixel_tick)
        begin
            if (h_wrap)
            begin
                h_count <= '0;                     // new line
                if (v_count == vga_pkg::V_TOTAL - 10'd1)
                begin
                    v_count <= '0;                 // new frame
                end
                else
                begin
                    v_count <= v_count + 10'd1;
                end
            end
            else
            begin
                h_count <= h_count + 10'd1;
            end
        end
    end

    assign h_sync_raw = (h_count < vga_pkg::H_SYNC_END);  // high at start of line
    assign v_sync_raw = (v_count < vga_pkg::V_SYNC_END);  // first two lines

    // counters never reach their period value
    a_counts_in_range: assert property (@(posedge clk) disable iff (reset)
        (h_count < vga_pkg::H_TOTAL) && (v_count < vga_pkg::V_TOTAL));

    // strobe is isolated, downstream stages rely on it
    a_tick_single: assert property (@(posedge clk) disable iff (reset)
        pixel_tick |=> !pixel_tick);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module vga_control_tb \
    -f vga_control.f \
    -o vga_control_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output="$(./obj_dir/vga_control_sim)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test completed successfully"; then
    exit 0
else
    exit 1
fi

/* testbench/vga_control_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_control_tb;

    localparam int          CLK_DIV  = 4;
    localparam int          LINE_CYC = 800 * CLK_DIV;          // clk cycles per line
    localparam logic [31:0] SEED     = 32'hbb84_ad13;
    localparam int          EDGE_H [8] = '{324, 370, 371, 382, 545, 556, 557, 603};

    logic            clk = 1'b0;
    logic            reset;
    vga_pkg::color_t r;
    vga_pkg::color_t g;
    vga_pkg::color_t b;
    logic            horizontal_sync;
    logic            vertical_sync;

    // reference model counters and the two stage delay line
    int          m_div;
    int          m_h;
    int          m_v;
    int          s1_h;
    int          s1_v;
    int          e_h;
    int          e_v;
    logic [11:0] s1_col;                                       // packed r,g,b
    logic [11:0] e_col;
    logic        s1_hs;
    logic        s1_vs;
    logic        s1_vis;
    logic        e_hs;
    logic        e_vs;
    logic        rst_q;                                        // reset seen by last edge

    // pin monitors
    int          cyc = 0;
    int          hs_rise_at = 0;
    int          vs_rise_at = 0;
    int          since_rel = 0;                                // negedges since reset release
    bit          hs_valid = 1'b0;
    bit          vs_valid = 1'b0;
    bit          recov_wait = 1'b0;
    bit          prev_hs = 1'b0;
    bit          prev_vs = 1'b0;
    int          tgt_h = 144;                                  // next sampled column
    logic [31:0] pix_rnd = ~SEED;
    logic [31:0] stim_rnd = SEED;

    int    test_chk [6];
    int    test_err [6];
    string test_name [6] = '{"pin model", "hsync timing", "vsync timing", "blanking",
                             "pattern colors", "reset recovery"};

    vga_control #(.CLK_DIV(CLK_DIV)) vga_control_i (
        .clk(clk), .reset(reset), .r(r), .g(g), .b(b),
        .horizontal_sync(horizontal_sync), .vertical_sync(vertical_sync)
    );

    always #10 clk = ~clk;                                     // 50 MHz sim clock

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic bit in_window(input int h, input int v);
        return (h >= 144) && (h <= 783) && (v >= 35) && (v <= 514);
    endfunction

    // white field with a yellow panel and black marks inside the panel
    function automatic logic [11:0] region_color(input int h, input int v);
        bit panel;
        bit mark;
        panel = (h >= 324) && (h <= 603) && (v >= 135) && (v <= 413);
        mark  = ((v >= 205) && (v <= 216)
                 && (((h >= 371) && (h <= 382)) || ((h >= 545) && (h <= 556))))
             || ((v >= 305) && (v <= 309) && (h >= 371) && (h <= 556));
        if (panel && mark)
        begin
            return 12'h000;
        end
        return panel ? 12'hff0 : 12'hfff;
    endfunction

    task automatic check(input int test, input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        test_chk[test]++;
        if (expected !== actual)
        begin
            test_err[test]++;
            if (test_err[test] <= 10)
            begin
                $display("[FAIL] %s expected %h actual %h at %0t", name, expected, actual,
                         $time);
            end
        end
    endtask

    always @(posedge clk)
    begin
        rst_q <= reset;
        if (reset)
        begin
            m_div  <= 0;
            m_h    <= 0;
            m_v    <= 0;
            s1_h   <= 0;
            s1_v   <= 0;
            s1_col <= 12'h000;
            s1_hs  <= 1'b0;
            s1_vs  <= 1'b0;
            s1_vis <= 1'b0;
            e_h    <= 0;
            e_v    <= 0;
            e_col  <= 12'h000;
            e_hs   <= 1'b0;
            e_vs   <= 1'b0;
        end
        else if (m_div == CLK_DIV - 1)                         // pixel tick
        begin
            m_div <= 0;
            m_h   <= (m_h == 799) ? 0 : m_h + 1;
            if (m_h == 799)
            begin
                m_v <= (m_v == 524) ? 0 : m_v + 1;
            end
            s1_h   <= m_h;
            s1_v   <= m_v;
            s1_col <= region_color(m_h, m_v);
            s1_hs  <= (m_h < 96);
            s1_vs  <= (m_v < 2);
            s1_vis <= in_window(m_h, m_v);
            e_h    <= s1_h;
            e_v    <= s1_v;
            e_col  <= s1_vis ? s1_col : 12'h000;               // blanking
            e_hs   <= s1_hs;
            e_vs   <= s1_vs;
        end
        else
        begin
            m_div <= m_div + 1;
        end
    end

    // sample mid cycle while the pins are settled
    always @(negedge clk)
    begin
        cyc = cyc + 1;
        check(0, "rgb", 32'(e_col), 32'({r, g, b}));
        check(0, "horizontal_sync", 32'(e_hs), 32'(horizontal_sync));
        check(0, "vertical_sync", 32'(e_vs), 32'(vertical_sync));
        if (rst_q)
        begin
            check(5, "rgb in reset", 0, 32'({r, g, b}));
            check(5, "sync pins in reset", 0, 32'({horizontal_sync, vertical_sync}));
            hs_valid   = 1'b0;
            vs_valid   = 1'b0;
            recov_wait = 1'b1;
            since_rel  = 0;
        end
        else
        begin
            if (!in_window(e_h, e_v))
            begin
                check(3, "rgb blanked", 0, 32'({r, g, b}));
            end
            else if (e_h == tgt_h)
            begin
                check(4, "rgb pattern", 32'(region_color(e_h, e_v)), 32'({r, g, b}));
                pix_rnd = lcg_next(pix_rnd);
                if (pix_rnd[31])
                begin
                    tgt_h = EDGE_H[pix_rnd[18:16]];            // region edge column
                end
                else
                begin
                    tgt_h = 144 + int'(pix_rnd[30:16] % 640);
                end
            end
            if (recov_wait)
            begin
                since_rel = since_rel + 1;
                if (horizontal_sync)
                begin
                    check(5, "clk cycles to first horizontal_sync", 2 * CLK_DIV, since_rel);
                    recov_wait = 1'b0;
                end
                else if (since_rel > 4 * CLK_DIV)
                begin
                    $display("reset recovery: horizontal_sync did not rise after release");
                    test_err[5]++;
                    recov_wait = 1'b0;
                end
            end
            if (horizontal_sync && !prev_hs)
            begin
                if (hs_valid)
                begin
                    check(1, "horizontal_sync period", LINE_CYC, cyc - hs_rise_at);
                end
                hs_valid   = 1'b1;
                hs_rise_at = cyc;
            end
            if (!horizontal_sync && prev_hs && hs_valid)
            begin
                check(1, "horizontal_sync width", 96 * CLK_DIV, cyc - hs_rise_at);
            end
            if (vertical_sync != prev_vs)                      // edges sit on an hsync rise
            begin
                check(2, "horizontal_sync rise at vsync edge", 1,
                      32'(horizontal_sync && !prev_hs));
            end
            if (vertical_sync && !prev_vs)
            begin
                if (vs_valid)
                begin
                    check(2, "vertical_sync period", 525 * LINE_CYC, cyc - vs_rise_at);
                end
                vs_valid   = 1'b1;
                vs_rise_at = cyc;
            end
            if (!vertical_sync && prev_vs && vs_valid)
            begin
                check(2, "vertical_sync width", 2 * LINE_CYC, cyc - vs_rise_at);
            end
        end
        prev_hs = horizontal_sync;
        prev_vs = vertical_sync;
    end

    initial
    begin
        int len;
        int failed;
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        for (int p = 0; p < 2; p++)                            // random reset pulses
        begin
            stim_rnd = lcg_next(stim_rnd);
            repeat (900_000 + int'(stim_rnd[31:12] % 700_000)) @(posedge clk);
            stim_rnd = lcg_next(stim_rnd);
            len = 1 + int'(stim_rnd[31]);
            #1 reset = 1'b1;
            repeat (len) @(posedge clk);
            #1 reset = 1'b0;
        end
        repeat (1_700_000) @(posedge clk);                     // one full frame after last reset
        failed = 0;
        for (int t = 0; t < 6; t++)
        begin
            if (test_chk[t] == 0)
            begin
                $display("%s: no samples were checked", test_name[t]);
                failed++;
            end
            else if (test_err[t] != 0)
            begin
                $display("%s: %0d of %0d checks wrong", test_name[t], test_err[t], test_chk[t]);
                failed++;
            end
            else
            begin
                $display("%s: ok, %0d checks", test_name[t], test_chk[t]);
            end
        end
        $display("tests passed %0d, tests failed %0d", 6 - failed, failed);
        if (failed == 0)
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vga_control.f */
hdl/vga_pkg.sv
hdl/vga_timing.sv
hdl/vga_pattern.sv
hdl/vga_output.sv
hdl/vga_control.sv
testbench/vga_control_tb.sv
